// File: src.f
common/zx_bus_pkg.sv
common/zx_map_pkg.sv
common/port_wr_if.sv
verilog/port_decoder.sv
verilog/frame_timer.sv
verilog/nmi_fsm.sv
pager/mem_pager.sv
verilog/zx_sysctl.sv
sim/tb_zx_sysctl.sv

// File: Makefile
TOP := tb_zx_sysctl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	verilator --lint-only -Wall --timing --top-module zx_sysctl -f src.f

clean:
	rm -rf obj_dir

// File: sim/tb_zx_sysctl.sv
`default_nettype none

module tb_zx_sysctl;

	localparam int FRAME_LEN = 200;
	localparam int INT_LEN   = 32;
	localparam int CLK_HALF  = 4;

	logic        fclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic        int_n;
	logic        nmi_n;
	logic        mem_ram;
	logic [6:0]  mem_page;
	logic        dos;

	// window map as the testbench expects it
	logic       exp_ram  [4];
	logic [6:0] exp_page [4];
	int         cycle = 0;

	zx_sysctl #(
		.FRAME_LEN    (FRAME_LEN),
		.INT_LEN      (INT_LEN),
		.NMI_ROM_PAGE (2)
	) UUT (.*);

	initial
	begin
		fclk = 1'b0;
		forever #CLK_HALF fclk = ~fclk;
	end

	always @(posedge fclk)
		cycle <= cycle + 1;

	// 20 frames is far more than all tests together need
	initial
	begin
		#(20 * FRAME_LEN * 2 * CLK_HALF);
		$display("ERROR: watchdog expired, the DUT never gave the awaited response");
		$display("Simulation FAILED");
		$fatal(1, "watchdog");
	end

	////////////////////
	// bus helpers
	////////////////////

	task automatic report_mismatch(input string test_name, input int expv, input int actv);
		$display("MISMATCH %s expected %0h actual %0h", test_name, expv, actv);
		$display("Simulation FAILED");
		$fatal(1, "check failed in %s", test_name);
	endtask

	task automatic check_bit(input string test_name, input logic expv, input logic actv);
		assert (actv == expv)
		else report_mismatch(test_name, int'(expv), int'(actv));
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge fclk);
		a      <= addr;
		d      <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		@(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		@(posedge fclk);
		a      <= addr;
		m1_n   <= 1'b0;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(posedge fclk);
		m1_n   <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic mem_read(input logic [15:0] addr, output logic ram, output logic [6:0] page);
		@(posedge fclk);
		a      <= addr;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(negedge fclk);
		ram  = mem_ram;
		page = mem_page;
		@(posedge fclk);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic check_window(input string test_name, input logic [1:0] w);
		logic       ram;
		logic [6:0] page;
		mem_read({w, 14'h0123}, ram, page);
		assert (ram == exp_ram[w])
		else report_mismatch({test_name, " ram"}, int'(exp_ram[w]), int'(ram));
		assert (page == exp_page[w])
		else report_mismatch({test_name, " page"}, int'(exp_page[w]), int'(page));
	endtask

	task automatic check_all_windows(input string test_name);
		for (int w = 0; w < 4; w++)
			check_window(test_name, 2'(w));
	endtask

	// bit 7 picks ram page d[6:0] or rom page d[1:0]
	task automatic pager_write(input logic [1:0] w, input logic [7:0] data);
		io_write({w, 6'h00, 8'hF7}, data);
		exp_ram[w] = data[7];
		if (data[7])
			exp_page[w] = data[6:0];
		else
			exp_page[w] = {5'b0, data[1:0]};
		idle(2);
	endtask

	task automatic wait_int_fall();
		@(negedge fclk);
		while (int_n !== 1'b1)
			@(negedge fclk);
		while (int_n !== 1'b0)
			@(negedge fclk);
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic test_reset_map();
		check_all_windows("reset_map");
		check_bit("reset_map dos", 1'b0, dos);
		check_bit("reset_map int_n", 1'b1, int_n);
		check_bit("reset_map nmi_n", 1'b1, nmi_n);
	endtask

	task automatic test_paging();
		logic [1:0] w;
		logic [7:0] data;
		for (int i = 0; i < 12; i++)
		begin
			w    = 2'($urandom);
			data = 8'($urandom);
			// alternate between the ram and the rom view
			data[7] = i[0];
			pager_write(w, data);
			check_all_windows("paging");
		end
		// writes to other ports
		io_write(16'h40FE, 8'h85);
		io_write(16'hC0F6, 8'h81);
		idle(2);
		check_all_windows("paging other port");
	endtask

	task automatic test_frame_int();
		int t_fall;
		int low_len;
		wait_int_fall();
		t_fall  = cycle;
		low_len = 0;
		while (int_n == 1'b0)
		begin
			low_len++;
			@(negedge fclk);
		end
		assert (low_len == INT_LEN)
		else report_mismatch("frame_int length", INT_LEN, low_len);
		wait_int_fall();
		assert (cycle - t_fall == FRAME_LEN)
		else report_mismatch("frame_int period", FRAME_LEN, cycle - t_fall);
		// acknowledge a few cycles into this pulse
		idle(3);
		m1_n   <= 1'b0;
		iorq_n <= 1'b0;
		@(negedge fclk);
		check_bit("frame_int ack cycle", 1'b0, int_n);
		@(posedge fclk);
		m1_n   <= 1'b1;
		iorq_n <= 1'b1;
		@(negedge fclk);
		check_bit("frame_int after ack", 1'b1, int_n);
	endtask

	task automatic test_nmi();
		logic       ram;
		logic [6:0] page;
		pager_write(2'd0, 8'h89);
		// arm well clear of a frame start
		wait_int_fall();
		while (int_n == 1'b0)
			@(negedge fclk);
		io_write(16'h00BF, 8'h01);
		@(negedge fclk);
		while (int_n == 1'b1)
		begin
			check_bit("nmi before frame", 1'b1, nmi_n);
			@(negedge fclk);
		end
		check_bit("nmi at frame start", 1'b0, nmi_n);
		m1_fetch(16'h0066);
		@(negedge fclk);
		check_bit("nmi after vector fetch", 1'b1, nmi_n);
		mem_read(16'h0010, ram, page);
		assert (ram == 1'b0)
		else report_mismatch("nmi service ram", 0, int'(ram));
		assert (page == 7'd2)
		else report_mismatch("nmi service page", 2, int'(page));
		io_write(16'h00BF, 8'h02);
		idle(2);
		check_window("nmi cleared", 2'd0);
		check_bit("nmi cleared nmi_n", 1'b1, nmi_n);
	endtask

	task automatic test_dos();
		pager_write(2'd0, 8'h00);
		m1_fetch(16'h3D00);
		@(negedge fclk);
		check_bit("dos entry", 1'b1, dos);
		m1_fetch(16'h8000);
		@(negedge fclk);
		check_bit("dos exit", 1'b0, dos);
		pager_write(2'd0, 8'h83);
		m1_fetch(16'h3D00);
		@(negedge fclk);
		check_bit("dos from ram", 1'b0, dos);
	endtask

	initial
	begin
		void'($urandom(32'h84e3));
		rst_n  = 1'b0;
		a      = 16'h0000;
		d      = 8'h00;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		// rom 0, ram 5, ram 2, ram 0
		exp_ram[0]  = 1'b0;
		exp_page[0] = 7'd0;
		exp_ram[1]  = 1'b1;
		exp_page[1] = 7'd5;
		exp_ram[2]  = 1'b1;
		exp_page[2] = 7'd2;
		exp_ram[3]  = 1'b1;
		exp_page[3] = 7'd0;
		repeat (5) @(posedge fclk);
		rst_n <= 1'b1;
		test_reset_map();
		test_paging();
		test_frame_int();
		test_nmi();
		test_dos();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/zx_sysctl.sv
`default_nettype none

module zx_sysctl #(
	parameter int FRAME_LEN    = 71680,
	parameter int INT_LEN      = 32,
	parameter int NMI_ROM_PAGE = 2
) (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	output logic        int_n,
	output logic        nmi_n,
	output logic        mem_ram,
	output logic [6:0]  mem_page,
	output logic        dos
);

	logic int_start;
	logic in_nmi;

	port_wr_if wr_bus ();

	port_decoder u_port_decoder (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.a      (a),
		.d      (d),
		.iorq_n (iorq_n),
		.wr_n   (wr_n),
		.wr     (wr_bus.decoder)
	);

	frame_timer #(
		.FRAME_LEN (FRAME_LEN),
		.INT_LEN   (INT_LEN)
	) u_frame_timer (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.m1_n      (m1_n),
		.iorq_n    (iorq_n),
		.int_start (int_start),
		.int_n     (int_n)
	);

	nmi_fsm u_nmi_fsm (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.a         (a),
		.m1_n      (m1_n),
		.mreq_n    (mreq_n),
		.int_start (int_start),
		.wr        (wr_bus.nmi),
		.nmi_n     (nmi_n),
		.in_nmi    (in_nmi)
	);

	mem_pager #(
		.NMI_ROM_PAGE (NMI_ROM_PAGE)
	) u_mem_pager (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.m1_n     (m1_n),
		.mreq_n   (mreq_n),
		.in_nmi   (in_nmi),
		.wr       (wr_bus.pager),
		.mem_ram  (mem_ram),
		.mem_page (mem_page),
		.dos      (dos)
	);

	// a z80 bus cycle never reads and writes at once
	a_rd_wr_excl: assert property (@(posedge fclk) disable iff (!rst_n)
		!(!rd_n && !wr_n));

endmodule

`default_nettype wire

// File: pager/mem_pager.sv
`default_nettype none

module mem_pager #(
	parameter int NMI_ROM_PAGE = 2
) (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic        m1_n,
	input  logic        mreq_n,
	input  logic        in_nmi,
	port_wr_if.pager    wr,
	output logic        mem_ram,
	output logic [6:0]  mem_page,
	output logic        dos
);

	localparam int PW = zx_map_pkg::PAGE_W;

	zx_map_pkg::win_map_t win_map [zx_map_pkg::NUM_WIN];
	zx_map_pkg::win_map_t cur_map;
	logic [zx_map_pkg::WIN_W-1:0] cur_win;
	logic m1_fetch;

	////////////////////
	// window registers
	////////////////////

	for (genvar w = 0; w < zx_map_pkg::NUM_WIN; w++)
	begin : g_win
		always_ff @(posedge fclk or negedge rst_n)
		begin
			if (!rst_n)
				win_map[w] <= zx_map_pkg::RESET_MAP[w];
			else if (wr.pager_wr && wr.win == zx_map_pkg::WIN_W'(w))
			begin
				win_map[w].is_ram <= wr.wdata.ram.is_ram;
				// bit 7 picks the ram or the rom view
				if (wr.wdata.ram.is_ram)
					win_map[w].page <= wr.wdata.ram.page;
				else
					win_map[w].page <= PW'(wr.wdata.rom.page);
			end
		end
	end

	////////////////////
	// address mapping
	////////////////////

	assign cur_win = a[15:14];

	always_comb
	begin
		cur_map = win_map[cur_win];
		// service rom replaces window 0 during nmi
		if (in_nmi && cur_win == '0)
		begin
			cur_map.is_ram = 1'b0;
			cur_map.page   = PW'(NMI_ROM_PAGE);
		end
	end

	assign mem_ram  = cur_map.is_ram;
	assign mem_page = cur_map.page;

	////////////////////
	// dos flag
	////////////////////

	assign m1_fetch = ~m1_n & ~mreq_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (m1_fetch)
		begin
			// entry only from the rom mapped in window 0
			if (a[15:8] == zx_bus_pkg::DOS_ENTRY_HI && !win_map[0].is_ram)
				dos <= 1'b1;
			else if (a[15:14] != 2'b00)
				dos <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/nmi_fsm.sv
`default_nettype none

module nmi_fsm (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic        m1_n,
	input  logic        mreq_n,
	input  logic        int_start,
	port_wr_if.nmi      wr,
	output logic        nmi_n,
	output logic        in_nmi
);

	typedef enum logic [1:0] {
		IDLE,
		ARMED,
		ACTIVE,
		SERVICE
	} nmi_state_e;

	nmi_state_e state;
	nmi_state_e state_nx;
	logic       vec_fetch;

	// opcode fetch at the nmi entry point
	assign vec_fetch = ~m1_n & ~mreq_n & (a == zx_bus_pkg::NMI_VECTOR);

	always_comb
	begin
		state_nx = state;
		case (state)
			IDLE:    if (wr.set_nmi) state_nx = ARMED;
			// fires only at a frame start
			ARMED:   if (wr.clr_nmi) state_nx = IDLE;
			         else if (int_start) state_nx = ACTIVE;
			ACTIVE:  if (vec_fetch) state_nx = SERVICE;
			SERVICE: if (wr.clr_nmi) state_nx = IDLE;
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= IDLE;
			nmi_n  <= 1'b1;
			in_nmi <= 1'b0;
		end
		else
		begin
			state  <= state_nx;
			nmi_n  <= (state_nx != ACTIVE);
			in_nmi <= (state_nx == SERVICE);
		end
	end

	a_nmi_active: assert property (@(posedge fclk) disable iff (!rst_n)
		!nmi_n |-> state == ACTIVE);

endmodule

`default_nettype wire

// File: verilog/frame_timer.sv
`default_nettype none

module frame_timer #(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN   = 32
) (
	input  logic fclk,
	input  logic rst_n,
	input  logic m1_n,
	input  logic iorq_n,
	output logic int_start,
	output logic int_n
);

	localparam int CNT_W = $clog2(FRAME_LEN);
	localparam int INT_W = $clog2(INT_LEN + 1);

	logic [CNT_W-1:0] frame_cnt;
	logic [INT_W-1:0] int_cnt;
	logic             int_ack;

	// last cycle of the frame
	assign int_start = (frame_cnt == CNT_W'(FRAME_LEN - 1));

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (int_start)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	////////////////////
	// int_n pulse
	////////////////////

	// m1 together with iorq is the interrupt acknowledge
	assign int_ack = ~m1_n & ~iorq_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_n   <= 1'b1;
			int_cnt <= '0;
		end
		else if (int_start)
		begin
			int_n   <= 1'b0;
			int_cnt <= '0;
		end
		else if (!int_n)
		begin
			// ends on timeout or early on ack
			if (int_ack || int_cnt == INT_W'(INT_LEN - 1))
				int_n <= 1'b1;
			int_cnt <= int_cnt + 1'b1;
		end
	end

	a_int_len: assert property (@(posedge fclk) disable iff (!rst_n)
		$fell(int_n) |-> ##[1:INT_LEN] int_n);

endmodule

`default_nettype wire

// File: verilog/port_decoder.sv
`default_nettype none

module port_decoder (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	input  logic        iorq_n,
	input  logic        wr_n,
	port_wr_if.decoder  wr
);

	logic io_wr;
	logic io_wr_q;
	logic io_wr_start;
	logic hit_pager;
	logic hit_nmi;

	// z80 i/o write cycle, strobes treated as fclk synchronous
	assign io_wr       = ~iorq_n & ~wr_n;
	assign io_wr_start = io_wr & ~io_wr_q;

	assign hit_pager = (a[7:0] == zx_bus_pkg::PAGER_PORT_LO);
	assign hit_nmi   = (a[7:0] == zx_bus_pkg::NMI_PORT_LO);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_q     <= 1'b0;
			wr.pager_wr <= 1'b0;
			wr.set_nmi  <= 1'b0;
			wr.clr_nmi  <= 1'b0;
		end
		else
		begin
			io_wr_q     <= io_wr;
			wr.pager_wr <= io_wr_start & hit_pager;
			wr.set_nmi  <= io_wr_start & hit_nmi & d[zx_bus_pkg::NMI_SET_BIT];
			wr.clr_nmi  <= io_wr_start & hit_nmi & d[zx_bus_pkg::NMI_CLR_BIT];
		end
	end

	// window and data ride along with the strobe
	always_ff @(posedge fclk)
	begin
		if (io_wr_start)
		begin
			wr.win   <= a[15:14];
			wr.wdata <= d;
		end
	end

	// a long write cycle must not repeat the strobe
	a_strobe_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		(wr.pager_wr | wr.set_nmi | wr.clr_nmi) |=> !(wr.pager_wr | wr.set_nmi | wr.clr_nmi));

endmodule

`default_nettype wire

// File: common/port_wr_if.sv
`default_nettype none

// decoded i/o writes, all strobes are one fclk wide
interface port_wr_if;

	// pager port write with its window and data
	logic                         pager_wr;
	logic [zx_map_pkg::WIN_W-1:0] win;
	zx_map_pkg::pager_data_u      wdata;

	// nmi control port
	logic set_nmi;
	logic clr_nmi;

	modport decoder (
		output pager_wr,
		output win,
		output wdata,
		output set_nmi,
		output clr_nmi
	);

	modport pager (input pager_wr, input win, input wdata);

	modport nmi (input set_nmi, input clr_nmi);

endinterface

`default_nettype wire

// File: common/zx_map_pkg.sv
`default_nettype none

// memory map of the four 16k cpu windows
package zx_map_pkg;

	localparam int WIN_W   = 2;
	localparam int NUM_WIN = 4;
	localparam int PAGE_W  = 7;

	// pager write byte, decoded by bit 7
	typedef struct packed {
		logic              is_ram;
		logic [PAGE_W-1:0] page;
	} ram_view_t;

	typedef struct packed {
		logic       is_ram;
		logic [4:0] rsvd;
		logic [1:0] page;
	} rom_view_t;

	typedef union packed {
		ram_view_t ram;
		rom_view_t rom;
	} pager_data_u;

	typedef struct packed {
		logic              is_ram;
		logic [PAGE_W-1:0] page;
	} win_map_t;

	// rom 0, ram 5, ram 2, ram 0
	localparam win_map_t [NUM_WIN-1:0] RESET_MAP = '{
		3: '{is_ram: 1'b1, page: 7'd0},
		2: '{is_ram: 1'b1, page: 7'd2},
		1: '{is_ram: 1'b1, page: 7'd5},
		0: '{is_ram: 1'b0, page: 7'd0}
	};

endpackage

`default_nettype wire

// File: common/zx_bus_pkg.sv
`default_nettype none

// z80 bus-side constants shared by the port decoder, nmi sequencer and pager
package zx_bus_pkg;

	////////////////////
	// i/o port decode
	////////////////////

	// memory pager, window number comes from a[15:14]
	localparam logic [7:0] PAGER_PORT_LO = 8'hF7;

	// nmi control port
	localparam logic [7:0] NMI_PORT_LO = 8'hBF;

	// data bits of the nmi control write
	localparam int NMI_SET_BIT = 0;
	localparam int NMI_CLR_BIT = 1;

	////////////////////
	// z80 vectors
	////////////////////

	// fixed nmi entry point of the cpu
	localparam logic [15:0] NMI_VECTOR = 16'h0066;

	// high byte of the trdos entry area in rom
	localparam logic [7:0] DOS_ENTRY_HI = 8'h3D;

endpackage

`default_nettype wire
